// File: dv/mmio_tb.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_tb;
    import mmio_pkg::*;

    localparam int NUM_ACCESSES    = 42;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 20 + 200;
    localparam int ACK_TIMEOUT     = 20;
    // Idle request between tests is an unmapped read
    localparam cpu_req_t PARK_REQ  = {32'h0002_0000, 32'h0, 1'b1, 1'b0};

    logic        clk;
    logic        reset;
    cpu_req_t    cpu_req;
    logic [4:0]  button_i;
    logic [1:0]  app_i;
    logic        rising_i;
    logic        disp_ack_i;
    logic [31:0] instr_o;
    logic [31:0] rdata_o;
    logic        i_ack_o;
    logic        d_ack_o;
    disp_wr_t    disp_o;
    logic        wen_o;

    // Results of the most recent access
    logic [31:0] last_rdata;
    logic [31:0] last_instr;
    logic        last_i_ack;
    logic        last_d_ack;
    logic        last_ack_after;
    logic        last_wen_at_ack;
    disp_wr_t    last_disp;
    int          last_latency;
    int          last_wen_cycles;

    int error_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int seed = 1215;
    int disp_delay = 4;
    int wen_count = 0;

    mmio uut (
        .clk        (clk),
        .reset      (reset),
        .cpu_req_i  (cpu_req),
        .button_i   (button_i),
        .app_i      (app_i),
        .rising_i   (rising_i),
        .disp_ack_i (disp_ack_i),
        .instr_o    (instr_o),
        .rdata_o    (rdata_o),
        .i_ack_o    (i_ack_o),
        .d_ack_o    (d_ack_o),
        .disp_o     (disp_o),
        .wen_o      (wen_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    // Display answers once wen_o has been high for disp_delay cycles
    initial begin
        disp_ack_i = 1'b0;
        forever begin
            @(negedge clk);
            if (disp_ack_i) begin
                disp_ack_i <= 1'b0;
                wen_count = 0;
            end else if (wen_o) begin
                wen_count++;
                if (wen_count >= disp_delay) disp_ack_i <= 1'b1;
            end
        end
    end

    function automatic cpu_req_t build_req(logic [31:0] addr, logic [31:0] wdata,
                                           logic read, logic write);
        cpu_req_t req;
        req.addr  = addr;
        req.wdata = wdata;
        req.read  = read;
        req.write = write;
        return req;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_key(input string name, input key_word_t got, input key_word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h (pending %0h app %0h button %02h), expected 0x%08h",
                     name, got, got.pending, got.app, got.button, exp);
            error_count++;
        end
    endtask

    task automatic check_disp(input string name, input disp_wr_t got, input disp_wr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = addr 0x%08h data 0x%08h, expected addr 0x%08h data 0x%08h",
                     name, got.addr, got.data, exp.addr, exp.data);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // Fetch gets i_ack_o, data access d_ack_o, and the pulse lasts one cycle
    task automatic expect_ack(input logic fetch);
        check_bit("i_ack_o", last_i_ack, fetch);
        check_bit("d_ack_o", last_d_ack, !fetch);
        check_bit("ack in turnaround", last_ack_after, 1'b0);
    endtask

    task automatic do_access(input cpu_req_t req);
        int  cycles;
        bit  acked;
        acked = 0;
        cycles = 0;
        // Let the parked access finish first
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            acked = i_ack_o | d_ack_o;
            cycles++;
        end
        if (!acked) begin
            $display("Parked request was never acknowledged");
            error_count++;
        end
        @(negedge clk);
        cpu_req <= req;
        acked = 0;
        cycles = 0;
        last_wen_cycles = 0;
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            if (cycles == 0) last_disp = disp_o;
            acked = i_ack_o | d_ack_o;
            if (!acked && wen_o) last_wen_cycles++;
            cycles++;
        end
        if (!acked) begin
            $display("No acknowledge within %0d cycles for address 0x%08h", ACK_TIMEOUT, req.addr);
            error_count++;
        end
        last_latency    = cycles - 1;
        last_i_ack      = i_ack_o;
        last_d_ack      = d_ack_o;
        last_rdata      = rdata_o;
        last_instr      = instr_o;
        last_wen_at_ack = wen_o;
        @(negedge clk);
        last_ack_after = i_ack_o | d_ack_o;
        cpu_req <= PARK_REQ;
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("[PASS] test %0d %s", num, name);
        end else begin
            tests_failed++;
            $display("[FAIL] test %0d %s, %0d errors", num, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    task automatic test_ram_rw();
        do_access(build_req(32'h0000_0084, 32'hA5C3_0F12, 1'b0, 1'b1));
        expect_ack(1'b0);
        do_access(build_req(32'h0000_0084, 32'h0, 1'b1, 1'b0));
        expect_ack(1'b0);
        check_word("rdata_o", last_rdata, 32'hA5C3_0F12);
        finish_test(1, "RAM write and read");
    endtask

    task automatic test_fetch();
        do_access(build_req(32'h0000_0040, 32'h1300_0513, 1'b0, 1'b1));
        do_access(build_req(32'h0000_0040, 32'h0, 1'b0, 1'b0));
        expect_ack(1'b1);
        check_word("instr_o", last_instr, 32'h1300_0513);
        finish_test(2, "instruction fetch");
    endtask

    task automatic test_keypad();
        key_word_t exp;
        @(negedge clk);
        button_i <= 5'h13;
        app_i    <= 2'h2;
        rising_i <= 1'b1;
        @(negedge clk);
        rising_i <= 1'b0;
        // Pin codes change but the latched ones must not
        button_i <= 5'h04;
        app_i    <= 2'h0;
        exp.pending = 1'b1;
        exp.zero    = '0;
        exp.app     = 2'h2;
        exp.button  = 5'h13;
        do_access(build_req(`MMIO_KEY_ADDR, 32'h0, 1'b1, 1'b0));
        expect_ack(1'b0);
        check_key("rdata_o", key_word_t'(last_rdata), exp);
        check_word("keypad latency", 32'(last_latency), `MMIO_KEY_LATENCY);
        exp.pending = 1'b0;
        do_access(build_req(`MMIO_KEY_ADDR, 32'h0, 1'b1, 1'b0));
        check_key("rdata_o", key_word_t'(last_rdata), exp);
        finish_test(3, "keypad read");
    endtask

    task automatic test_display();
        disp_wr_t exp;
        exp.addr = 32'h8000_0010;
        exp.data = 32'h5566_7788;
        do_access(build_req(32'h0000_0010, 32'h0BAD_F00D, 1'b0, 1'b1));
        do_access(build_req(exp.addr, exp.data, 1'b0, 1'b1));
        expect_ack(1'b0);
        check_disp("disp_o", last_disp, exp);
        check_word("wen_o high cycles", 32'(last_wen_cycles), 32'(disp_delay));
        check_bit("wen_o in ack cycle", last_wen_at_ack, 1'b0);
        check_word("display latency", 32'(last_latency), 32'(disp_delay));
        // RAM word under the same low address bits stays untouched
        do_access(build_req(32'h0000_0010, 32'h0, 1'b1, 1'b0));
        check_word("rdata_o", last_rdata, 32'h0BAD_F00D);
        finish_test(4, "display write");
    endtask

    task automatic test_unmapped();
        do_access(build_req(32'h0002_0000, 32'h0, 1'b1, 1'b0));
        expect_ack(1'b0);
        check_word("rdata_o", last_rdata, `MMIO_BAD_WORD);
        check_word("unmapped latency", 32'(last_latency), 32'd1);
        finish_test(5, "unmapped read");
    endtask

    task automatic test_random_ram();
        logic [31:0] model_mem [8];
        int          idx_list [16];
        logic [31:0] data;
        // Only eight words so that some addresses repeat
        for (int i = 0; i < 16; i++) begin
            idx_list[i] = $random(seed) & 7;
            data = $random(seed);
            model_mem[idx_list[i]] = data;
            do_access(build_req(32'h200 + idx_list[i] * 4, data, 1'b0, 1'b1));
        end
        for (int i = 15; i >= 0; i--) begin
            do_access(build_req(32'h200 + idx_list[i] * 4, 32'h0, 1'b1, 1'b0));
            check_word($sformatf("rdata_o @0x%08h", 32'h200 + idx_list[i] * 4),
                       last_rdata, model_mem[idx_list[i]]);
        end
        finish_test(6, "random RAM writes and reads");
    endtask

    initial begin
        reset    = 1'b1;
        cpu_req  = PARK_REQ;
        button_i = 5'h0;
        app_i    = 2'h0;
        rising_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_ram_rw();
        test_fetch();
        test_keypad();
        test_display();
        test_unmapped();
        test_random_ram();
        $display("Summary: %0d tests, %0d passed, %0d failing, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/ack_controller.sv
`timescale 1ns/1ps

module ack_controller (
    input  logic              clk,
    input  logic              reset,
    input  mmio_pkg::region_e region_i,
    input  logic              fetch_i,
    input  logic              ram_done_i,
    input  logic              key_ready_i,
    input  logic              disp_ack_i,
    output logic              start_o,
    output logic              wen_o,
    output logic              i_ack_o,
    output logic              d_ack_o
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_TURN
    } state_e;

    state_e state_q;
    logic   disp_ack_q;
    logic   done;
    logic   complete;

    // Completion event of the selected region
    always_comb begin
        case (region_i)
            REG_RAM:  done = ram_done_i;
            REG_KEY:  done = key_ready_i;
            REG_DISP: done = disp_ack_q;
            default:  done = 1'b1;
        endcase
    end

    assign start_o  = (state_q == S_IDLE);
    assign complete = (state_q == S_BUSY) & done;
    assign i_ack_o  = complete & fetch_i;
    assign d_ack_o  = complete & ~fetch_i;

    // Write enable held from the start cycle until the display answers
    assign wen_o = (region_i == REG_DISP) & (state_q != S_TURN) & ~disp_ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q    <= S_IDLE;
            disp_ack_q <= 1'b0;
        end else begin
            disp_ack_q <= disp_ack_i;
            case (state_q)
                S_IDLE:  state_q <= S_BUSY;
                S_BUSY:  state_q <= complete ? S_TURN : S_BUSY;
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/keypad_register.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module keypad_register (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          button_i,
    input  logic [1:0]          app_i,
    input  logic                rising_i,
    input  logic                start_i,
    output mmio_pkg::key_word_t word_o,
    output logic                ready_o
);
    localparam int LAT = `MMIO_KEY_LATENCY;

    logic [LAT-1:0] delay_q;
    logic           pending_q;
    logic [4:0]     button_q;
    logic [1:0]     app_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            delay_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            // Fixed read latency, one stage per cycle
            delay_q <= (delay_q << 1) | LAT'(start_i);

            // A new key press beats the clear from a read
            if (rising_i) begin
                pending_q <= 1'b1;
            end else if (ready_o) begin
                pending_q <= 1'b0;
            end
        end
    end

    // Captured codes
    always_ff @(posedge clk) begin
        if (rising_i) begin
            button_q <= button_i;
            app_q    <= app_i;
        end
    end

    assign ready_o = delay_q[LAT-1];

    always_comb begin
        word_o.pending = pending_q;
        word_o.zero    = '0;
        word_o.app     = app_q;
        word_o.button  = button_q;
    end

endmodule

// File: hdl/mmio.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::cpu_req_t cpu_req_i,
    input  logic [4:0]         button_i,
    input  logic [1:0]         app_i,
    input  logic               rising_i,
    input  logic               disp_ack_i,
    output logic [31:0]        instr_o,
    output logic [31:0]        rdata_o,
    output logic               i_ack_o,
    output logic               d_ack_o,
    output mmio_pkg::disp_wr_t disp_o,
    output logic               wen_o
);
    import mmio_pkg::*;

    region_e   region;
    region_e   eff_region;
    logic      fetch;
    logic      rd;
    logic      wr;
    logic      start;
    logic      ram_done;
    logic      key_ready;
    logic [31:0] ram_rdata;
    key_word_t key_word;
    wb_m2s_t   wb_m2s;
    wb_s2m_t   wb_s2m;

    mmio_addr_decoder u_decoder (
        .req_i    (cpu_req_i),
        .region_o (region),
        .fetch_o  (fetch),
        .rd_o     (rd),
        .wr_o     (wr)
    );

    // Display only takes writes, anything else there is unmapped
    assign eff_region = (region == REG_DISP && !wr) ? REG_NONE : region;

    ack_controller u_ack (
        .clk         (clk),
        .reset       (reset),
        .region_i    (eff_region),
        .fetch_i     (fetch),
        .ram_done_i  (ram_done),
        .key_ready_i (key_ready),
        .disp_ack_i  (disp_ack_i),
        .start_o     (start),
        .wen_o       (wen_o),
        .i_ack_o     (i_ack_o),
        .d_ack_o     (d_ack_o)
    );

    keypad_register u_keypad (
        .clk      (clk),
        .reset    (reset),
        .button_i (button_i),
        .app_i    (app_i),
        .rising_i (rising_i),
        .start_i  (start && eff_region == REG_KEY),
        .word_o   (key_word),
        .ready_o  (key_ready)
    );

    wishbone_manager u_wb_mgr (
        .clk     (clk),
        .reset   (reset),
        .start_i (start && eff_region == REG_RAM),
        .req_i   (cpu_req_i),
        .wb_i    (wb_s2m),
        .wb_o    (wb_m2s),
        .rdata_o (ram_rdata),
        .done_o  (ram_done)
    );

    sram_wb u_sram (
        .clk   (clk),
        .reset (reset),
        .wb_i  (wb_m2s),
        .wb_o  (wb_s2m)
    );

    // Read data by region, writes get no data back
    always_comb begin
        rdata_o = `MMIO_BAD_WORD;
        if (rd || fetch) begin
            case (eff_region)
                REG_RAM: rdata_o = ram_rdata;
                REG_KEY: rdata_o = key_word;
                default: rdata_o = `MMIO_BAD_WORD;
            endcase
        end
    end

    assign instr_o = rdata_o;

    always_comb begin
        disp_o.addr = cpu_req_i.addr;
        disp_o.data = cpu_req_i.wdata;
    end

endmodule

// File: hdl/mmio_addr_decoder.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_addr_decoder (
    input  mmio_pkg::cpu_req_t req_i,
    output mmio_pkg::region_e  region_o,
    output logic               fetch_o,
    output logic               rd_o,
    output logic               wr_o
);
    import mmio_pkg::*;

    localparam logic [31:0] RAM_BYTES = `MMIO_RAM_WORDS * 4;

    logic [31:0] ram_offset;
    logic        disp_hit;

    // Offset wraps high for addresses below the base, so one compare covers both ends
    assign ram_offset = req_i.addr - `MMIO_RAM_BASE;
    assign disp_hit   = |(req_i.addr & `MMIO_DISP_BASE);

    always_comb begin
        if (disp_hit) begin
            region_o = REG_DISP;
        end else if (req_i.addr == `MMIO_KEY_ADDR) begin
            region_o = REG_KEY;
        end else if (ram_offset < RAM_BYTES) begin
            region_o = REG_RAM;
        end else begin
            region_o = REG_NONE;
        end
    end

    // Write wins if the CPU ever raises both strobes
    assign wr_o    = req_i.write;
    assign rd_o    = req_i.read & ~req_i.write;
    assign fetch_o = ~req_i.read & ~req_i.write;

endmodule

// File: hdl/mmio_pkg.sv
package mmio_pkg;

    // Level-held CPU request, fetch when neither strobe is set
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } cpu_req_t;

    typedef enum logic [1:0] {
        REG_RAM,
        REG_KEY,
        REG_DISP,
        REG_NONE
    } region_e;

    // Wishbone B4 classic, manager to subordinate
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_m2s_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_s2m_t;

    // Keypad status word as software sees it
    typedef struct packed {
        logic        pending;
        logic [23:0] zero;
        logic [1:0]  app;
        logic [4:0]  button;
    } key_word_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } disp_wr_t;

endpackage

// File: hdl/sram_wb.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module sram_wb (
    input  logic              clk,
    input  logic              reset,
    input  mmio_pkg::wb_m2s_t wb_i,
    output mmio_pkg::wb_s2m_t wb_o
);
    localparam int AW = $clog2(`MMIO_RAM_WORDS);

    logic [31:0]   mem [`MMIO_RAM_WORDS];
    logic [AW-1:0] word_addr;
    logic [31:0]   dat_q;
    logic          ack_q;
    logic          access;

    // Byte address in, word index out
    assign word_addr = wb_i.adr[AW+1:2];

    // No second access while the ack for this one is on the bus
    assign access = wb_i.stb & wb_i.cyc & ~ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[word_addr][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
            dat_q <= mem[word_addr];
        end
    end

    // Zero wait states, ack one cycle after strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_comb begin
        wb_o.dat = dat_q;
        wb_o.ack = ack_q;
    end

endmodule

// File: hdl/wishbone_manager.sv
`timescale 1ns/1ps

module wishbone_manager (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_i,
    input  mmio_pkg::cpu_req_t req_i,
    input  mmio_pkg::wb_s2m_t  wb_i,
    output mmio_pkg::wb_m2s_t  wb_o,
    output logic [31:0]        rdata_o,
    output logic               done_o
);
    // Bus cycle control
    logic        stb_q;
    logic        cyc_q;
    logic        done_q;

    // Request captured at start
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic        we_q;

    logic [31:0] rdata_q;
    logic        bus_ack;
    logic        launch;

    // Only one Wishbone cycle in flight
    assign launch  = start_i & ~cyc_q;
    assign bus_ack = stb_q & wb_i.ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stb_q  <= 1'b0;
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= bus_ack;
            if (launch) begin
                stb_q <= 1'b1;
                cyc_q <= 1'b1;
            end else if (bus_ack) begin
                // Drop strobe and cycle on the ack edge
                stb_q <= 1'b0;
                cyc_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q <= req_i.addr;
            dat_q <= req_i.wdata;
            // Fetches and reads both go out as bus reads
            we_q  <= req_i.write;
        end
    end

    // Read data held until the next access
    always_ff @(posedge clk) begin
        if (bus_ack) begin
            rdata_q <= wb_i.dat;
        end
    end

    always_comb begin
        wb_o.adr = adr_q;
        wb_o.dat = dat_q;
        wb_o.sel = 4'hF;
        wb_o.we  = we_q;
        wb_o.stb = stb_q;
        wb_o.cyc = cyc_q;
    end

    assign rdata_o = rdata_q;
    assign done_o  = done_q;

endmodule

// File: include/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// Address map
`define MMIO_RAM_BASE    32'h0000_0000
`define MMIO_KEY_ADDR    32'h0001_0000
// Any address with bit 31 set belongs to the display
`define MMIO_DISP_BASE   32'h8000_0000

// RAM depth in 32-bit words
`define MMIO_RAM_WORDS   1024

// Cycles from start to keypad ready
`define MMIO_KEY_LATENCY 3

// Returned on reads of unmapped space
`define MMIO_BAD_WORD    32'hDEADBEEF

`endif

// File: mmio.f
+incdir+include
hdl/mmio_pkg.sv
hdl/mmio_addr_decoder.sv
hdl/keypad_register.sv
hdl/ack_controller.sv
hdl/wishbone_manager.sv
hdl/sram_wb.sv
hdl/mmio.sv
dv/mmio_tb.sv
